// ==== rtl/attr_decode.sv ====
`timescale 1ns/1ps

module attr_decode import video_mem_pkg::*; (
	input  logic      fclk,
	input  logic      rst_n,
	input  logic      pix_bit,
	input  vbyte_t    pix_attr,
	input  logic      pix_valid,
	input  logic      flash_phase,
	output zx_color_t color,
	output logic      color_valid
);

	logic       flash;
	logic       bright;
	logic       use_ink;
	logic [2:0] grb;

	// attribute: flash, bright, paper grb, ink grb
	assign flash  = pix_attr[7];
	assign bright = pix_attr[6];

	// flashing cells swap ink and paper in the second half of the cycle
	assign use_ink = pix_bit ^ (flash & flash_phase);
	assign grb     = use_ink ? pix_attr[2:0] : pix_attr[5:3];

	always_ff @(posedge fclk)
	begin
		color <= {bright, grb};
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			color_valid <= 1'b0;
		else
			color_valid <= pix_valid;
	end

endmodule

// ==== rtl/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing import video_timing_pkg::*; #(
	parameter hcount_t H_TOTAL      = 9'd448,
	parameter hcount_t H_BORDER_L   = 9'd64,
	parameter hcount_t H_SYNC_START = 9'd352,
	parameter hcount_t H_SYNC_LEN   = 9'd32,
	parameter vcount_t V_TOTAL      = 9'd320,
	parameter vcount_t V_BORDER_T   = 9'd64,
	parameter vcount_t V_SYNC_START = 9'd304,
	parameter vcount_t V_SYNC_LEN   = 9'd8,
	parameter int      INT_LEN      = 32
) (
	input  logic    fclk,
	input  logic    rst_n,
	output hcount_t hcount,
	output vcount_t vcount,
	output logic    pix_area,
	output logic    fetch_win,
	output logic    hsync,
	output logic    vsync,
	output logic    blank,
	output logic    flash_phase,
	output logic    int_n
);

	localparam int H_PIX_END   = int'(H_BORDER_L) + PIX_W;
	localparam int H_FETCH_BEG = int'(H_BORDER_L) - 8;
	localparam int H_FETCH_END = H_PIX_END - 8;
	localparam int V_PIX_END   = int'(V_BORDER_T) + PIX_H;
	localparam int H_SYNC_END  = int'(H_SYNC_START) + int'(H_SYNC_LEN);
	localparam int V_SYNC_END  = int'(V_SYNC_START) + int'(V_SYNC_LEN);
	localparam int INT_W       = $clog2(INT_LEN + 1);

	logic             line_end;
	logic             frame_end;
	logic             h_pix;
	logic             v_pix;
	logic             h_fetch;
	logic             h_sync;
	logic             v_sync;
	logic             int_start;
	logic [4:0]       frame_cnt;
	logic [INT_W-1:0] int_cnt;
	logic [2:0]       int_dly;

	assign line_end  = (hcount == H_TOTAL - 1'b1);
	assign frame_end = line_end && (vcount == V_TOTAL - 1'b1);

	// windows of the current position
	assign h_pix   = (hcount >= H_BORDER_L) && (int'(hcount) < H_PIX_END);
	assign v_pix   = (vcount >= V_BORDER_T) && (int'(vcount) < V_PIX_END);
	assign h_fetch = (int'(hcount) >= H_FETCH_BEG) && (int'(hcount) < H_FETCH_END);
	assign h_sync  = (hcount >= H_SYNC_START) && (int'(hcount) < H_SYNC_END);
	assign v_sync  = (vcount >= V_SYNC_START) && (int'(vcount) < V_SYNC_END);

	assign int_start = (hcount == '0) && (vcount == V_SYNC_START);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hcount <= '0;
			vcount <= '0;
		end
		else if (line_end)
		begin
			hcount <= '0;
			vcount <= (vcount == V_TOTAL - 1'b1) ? '0 : vcount + 1'b1;
		end
		else
			hcount <= hcount + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// registered flags, first stage of the video pipe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pix_area  <= 1'b0;
			fetch_win <= 1'b0;
			hsync     <= 1'b0;
			vsync     <= 1'b0;
			// dark until position 0 reaches the pins
			blank     <= 1'b1;
		end
		else
		begin
			pix_area  <= h_pix && v_pix;
			fetch_win <= h_fetch && v_pix;
			hsync     <= h_sync;
			vsync     <= v_sync;
			blank     <= h_sync || v_sync;
		end
	end

	// flash toggles every 16 frames
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (frame_end)
			frame_cnt <= frame_cnt + 1'b1;
	end

	assign flash_phase = frame_cnt[4];

	// int pulse, then delayed to line up with the pixel path
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_cnt <= '0;
			int_dly <= '0;
		end
		else
		begin
			if (int_start)
				int_cnt <= INT_W'(INT_LEN);
			else if (int_cnt != '0)
				int_cnt <= int_cnt - 1'b1;
			int_dly <= {int_dly[1:0], int_cnt != '0};
		end
	end

	assign int_n = ~int_dly[2];

endmodule

// ==== rtl/screen_fetch.sv ====
`timescale 1ns/1ps

module screen_fetch import video_timing_pkg::*, video_mem_pkg::*; #(
	parameter hcount_t H_BORDER_L = 9'd64,
	parameter vcount_t V_BORDER_T = 9'd64
) (
	input  logic    fclk,
	input  logic    rst_n,
	input  hcount_t hcount,
	input  vcount_t vcount,
	input  logic    fetch_win,
	input  logic    pix_area,
	input  vbyte_t  video_data,
	output vaddr_t  video_addr,
	output logic    video_strobe,
	output logic    pix_bit,
	output vbyte_t  pix_attr,
	output logic    pix_valid
);

	hcount_t      rel_col;
	logic         grp_start;
	logic [7:0]   y;
	logic [4:0]   col;
	logic         fetch_go;
	logic         load;
	logic [4:0]   attr_row;
	vaddr_t       attr_addr;
	fetch_state_t state;
	logic         attr_due;
	vbyte_t       bmp_hold;
	vbyte_t       attr_hold;
	vbyte_t       shreg;

	// hcount already points one column past the flagged position
	assign rel_col   = hcount - H_BORDER_L - 1'b1;
	assign grp_start = (rel_col[2:0] == 3'd0);

	// pixel line and the byte column of the group fetched 8 ahead
	assign y   = 8'(vcount - V_BORDER_T);
	assign col = rel_col[7:3] + 1'b1;

	assign fetch_go = (state == FETCH_IDLE) && fetch_win && grp_start;
	assign load     = pix_area && grp_start;

	// attribute cell taken straight from the bitmap address bits
	assign attr_row  = {video_addr[12:11], video_addr[7:5]};
	assign attr_addr = vaddr_t'(ATTR_BASE + ZX_COLS * attr_row + video_addr[4:0]);

	assign video_strobe = (state != FETCH_IDLE);

	////////////////////////////////////////////////////////////////////////////
	// read sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= FETCH_IDLE;
			attr_due <= 1'b0;
		end
		else
		begin
			// attribute byte shows up one cycle after the last strobe
			attr_due <= (state == FETCH_ATTR);
			case (state)
				FETCH_IDLE:
					if (fetch_go)
						state <= FETCH_BMP;
				FETCH_BMP:
					state <= FETCH_ATTR;
				default:
					state <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge fclk)
	begin
		// ZX swizzle: y[7:6], y[2:0], y[5:3], column
		if (fetch_go)
			video_addr <= {y[7:6], y[2:0], y[5:3], col};
		else if (state == FETCH_BMP)
			video_addr <= attr_addr;

		if (state == FETCH_ATTR)
			bmp_hold <= video_data;
		if (attr_due)
			attr_hold <= video_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// pixel shifter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (load)
		begin
			shreg    <= bmp_hold;
			pix_attr <= attr_hold;
		end
		else
			shreg <= {shreg[6:0], 1'b0};
	end

	// msb is the leftmost pixel
	assign pix_bit = shreg[7];

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			pix_valid <= 1'b0;
		else
			pix_valid <= pix_area;
	end

endmodule

// ==== rtl/video_mem_pkg.sv ====
package video_mem_pkg;

	// byte address into the 6912-byte screen
	typedef logic [12:0] vaddr_t;

	// one video memory byte
	typedef logic [7:0] vbyte_t;

	// colour index: bright, green, red, blue
	typedef logic [3:0] zx_color_t;

	// one analog-ish output component
	typedef logic [1:0] rgb2_t;

	////////////////////////////////////////////////////////////////////////////
	// ZX screen layout
	////////////////////////////////////////////////////////////////////////////

	// bitmap occupies 0..6143, attributes follow
	localparam int ATTR_BASE = 6144;

	// byte columns per line, also attribute cells per row
	localparam int ZX_COLS = 32;

endpackage

// ==== rtl/video_out.sv ====
`timescale 1ns/1ps

module video_out import video_mem_pkg::*; (
	input  logic      fclk,
	input  logic      rst_n,
	input  zx_color_t color,
	input  logic      color_valid,
	input  logic [2:0] border,
	input  logic      hsync,
	input  logic      vsync,
	input  logic      blank,
	output rgb2_t     vred,
	output rgb2_t     vgrn,
	output rgb2_t     vblu,
	output logic      vhsync,
	output logic      vvsync,
	output logic      vcsync
);

	logic [1:0] hs_dly;
	logic [1:0] vs_dly;
	logic [1:0] bl_dly;
	zx_color_t  pick;

	// set bit gives level 2, or 3 with bright
	function automatic rgb2_t expand(input logic on, input logic bright);
		return on ? {1'b1, bright} : 2'b00;
	endfunction

	// border has no bright
	assign pick = color_valid ? color : {1'b0, border};

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hs_dly <= '0;
			vs_dly <= '0;
			// blanked while the pipe fills
			bl_dly <= '1;
			vred   <= '0;
			vgrn   <= '0;
			vblu   <= '0;
			vhsync <= 1'b1;
			vvsync <= 1'b1;
			vcsync <= 1'b1;
		end
		else
		begin
			// raster flags wait two cycles for fetch and decode
			hs_dly <= {hs_dly[0], hsync};
			vs_dly <= {vs_dly[0], vsync};
			bl_dly <= {bl_dly[0], blank};

			if (bl_dly[1])
			begin
				vred <= '0;
				vgrn <= '0;
				vblu <= '0;
			end
			else
			begin
				vred <= expand(pick[1], pick[3]);
				vgrn <= expand(pick[2], pick[3]);
				vblu <= expand(pick[0], pick[3]);
			end

			// syncs are active low on the pins
			vhsync <= ~hs_dly[1];
			vvsync <= ~vs_dly[1];
			vcsync <= ~(hs_dly[1] | vs_dly[1]);
		end
	end

endmodule

// ==== rtl/video_timing_pkg.sv ====
package video_timing_pkg;

	////////////////////////////////////////////////////////////////////////////
	// raster counters
	////////////////////////////////////////////////////////////////////////////

	// column within a line, one step per fclk
	typedef logic [8:0] hcount_t;

	// line within a frame
	typedef logic [8:0] vcount_t;

	// native ZX display area
	localparam int PIX_W = 256;
	localparam int PIX_H = 192;

	////////////////////////////////////////////////////////////////////////////
	// fetch sequencer
	////////////////////////////////////////////////////////////////////////////

	// one bitmap and one attribute read per 8-pixel group
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_BMP,
		FETCH_ATTR
	} fetch_state_t;

endpackage

// ==== rtl/zx_video.sv ====
`timescale 1ns/1ps

module zx_video import video_timing_pkg::*, video_mem_pkg::*; #(
	parameter hcount_t H_TOTAL      = 9'd448,
	parameter hcount_t H_BORDER_L   = 9'd64,
	parameter hcount_t H_SYNC_START = 9'd352,
	parameter hcount_t H_SYNC_LEN   = 9'd32,
	parameter vcount_t V_TOTAL      = 9'd320,
	parameter vcount_t V_BORDER_T   = 9'd64,
	parameter vcount_t V_SYNC_START = 9'd304,
	parameter vcount_t V_SYNC_LEN   = 9'd8,
	parameter int      INT_LEN      = 32
) (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic [2:0] border,
	input  vbyte_t     video_data,
	output vaddr_t     video_addr,
	output logic       video_strobe,
	output rgb2_t      vred,
	output rgb2_t      vgrn,
	output rgb2_t      vblu,
	output logic       vhsync,
	output logic       vvsync,
	output logic       vcsync,
	output logic       int_n
);

	hcount_t   hcount;
	vcount_t   vcount;
	logic      pix_area;
	logic      fetch_win;
	logic      hsync;
	logic      vsync;
	logic      blank;
	logic      flash_phase;
	logic      pix_bit;
	vbyte_t    pix_attr;
	logic      pix_valid;
	zx_color_t color;
	logic      color_valid;

	////////////////////////////////////////////////////////////////////////////
	// timing -> fetch -> decode -> output
	////////////////////////////////////////////////////////////////////////////

	raster_timing #(
		.H_TOTAL(H_TOTAL), .H_BORDER_L(H_BORDER_L),
		.H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
		.V_TOTAL(V_TOTAL), .V_BORDER_T(V_BORDER_T),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN),
		.INT_LEN(INT_LEN)
	) timing (
		.fclk(fclk), .rst_n(rst_n),
		.hcount(hcount), .vcount(vcount),
		.pix_area(pix_area), .fetch_win(fetch_win),
		.hsync(hsync), .vsync(vsync), .blank(blank),
		.flash_phase(flash_phase), .int_n(int_n)
	);

	screen_fetch #(
		.H_BORDER_L(H_BORDER_L), .V_BORDER_T(V_BORDER_T)
	) fetch (
		.fclk(fclk), .rst_n(rst_n),
		.hcount(hcount), .vcount(vcount),
		.fetch_win(fetch_win), .pix_area(pix_area),
		.video_data(video_data), .video_addr(video_addr), .video_strobe(video_strobe),
		.pix_bit(pix_bit), .pix_attr(pix_attr), .pix_valid(pix_valid)
	);

	attr_decode decode (
		.fclk(fclk), .rst_n(rst_n),
		.pix_bit(pix_bit), .pix_attr(pix_attr), .pix_valid(pix_valid),
		.flash_phase(flash_phase),
		.color(color), .color_valid(color_valid)
	);

	video_out vout (
		.fclk(fclk), .rst_n(rst_n),
		.color(color), .color_valid(color_valid), .border(border),
		.hsync(hsync), .vsync(vsync), .blank(blank),
		.vred(vred), .vgrn(vgrn), .vblu(vblu),
		.vhsync(vhsync), .vvsync(vvsync), .vcsync(vcsync)
	);

endmodule

// ==== test/tb_zx_video.sv ====
`timescale 1ns/1ps

module tb_zx_video;

	localparam int H_TOTAL      = 320;
	localparam int H_BORDER_L   = 32;
	localparam int H_SYNC_START = 296;
	localparam int H_SYNC_LEN   = 16;
	localparam int V_TOTAL      = 240;
	localparam int V_BORDER_T   = 24;
	localparam int V_SYNC_START = 224;
	localparam int V_SYNC_LEN   = 4;
	localparam int INT_LEN      = 32;

	localparam int PIPE_LAT   = 3;
	localparam int FRAME      = H_TOTAL * V_TOTAL;
	localparam int RUN_FRAMES = 34;
	localparam int RUN_CYCLES = RUN_FRAMES * FRAME;
	localparam int MAX_CYCLES = (RUN_FRAMES + 1) * FRAME;
	// border swaps on a line inside vertical sync, fully blanked
	localparam int BORDER_SWAP = (V_SYNC_START + 1) * H_TOTAL;

	logic        fclk = 1'b0;
	logic        rst_n = 1'b0;
	logic [2:0]  border = 3'd0;
	logic [7:0]  video_data = 8'd0;
	logic [12:0] video_addr;
	logic        video_strobe;
	logic [1:0]  vred;
	logic [1:0]  vgrn;
	logic [1:0]  vblu;
	logic        vhsync;
	logic        vvsync;
	logic        vcsync;
	logic        int_n;

	logic [7:0]  mem [0:6911];
	logic [2:0]  border_tab [0:RUN_FRAMES+1];
	int          edge_cnt = 0;
	int          seed;
	int          dummy;
	int          i;
	int          pos;
	logic [10:0] want;

	always #10 fclk = ~fclk;

	zx_video #(
		.H_TOTAL(H_TOTAL), .H_BORDER_L(H_BORDER_L),
		.H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
		.V_TOTAL(V_TOTAL), .V_BORDER_T(V_BORDER_T),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN),
		.INT_LEN(INT_LEN)
	) dut0 (
		.fclk(fclk), .rst_n(rst_n), .border(border),
		.video_data(video_data), .video_addr(video_addr), .video_strobe(video_strobe),
		.vred(vred), .vgrn(vgrn), .vblu(vblu),
		.vhsync(vhsync), .vvsync(vvsync), .vcsync(vcsync), .int_n(int_n)
	);

	// video memory, one cycle read
	always @(posedge fclk)
	begin
		if (video_strobe)
			video_data <= mem[video_addr];
	end

	// cycle count since reset release, per-frame border
	always @(posedge fclk)
	begin
		if (rst_n)
		begin
			edge_cnt <= edge_cnt + 1;
			if (edge_cnt % FRAME == BORDER_SWAP)
				border <= border_tab[edge_cnt / FRAME + 1];
		end
	end

	always @(posedge fclk)
	begin
		if (edge_cnt >= MAX_CYCLES)
		begin
			$display("timeout: run went past %0d cycles without finishing", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$fatal(1, "run did not finish in time");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// bitmap read issued at this raster position
	function automatic logic fetch_cycle(input int p);
		int h;
		int v;
		if (p < 0)
			return 1'b0;
		h = p % H_TOTAL;
		v = (p / H_TOTAL) % V_TOTAL;
		return (v >= V_BORDER_T) && (v < V_BORDER_T + 192) && (h >= H_BORDER_L - 8)
			&& (h < H_BORDER_L + 248) && ((h - H_BORDER_L) % 8 == 0);
	endfunction

	// bitmap or attribute address of the group fetched from position p
	function automatic logic [12:0] fetch_addr(input int p, input logic attr_rd);
		int h;
		int y;
		int c;
		h = p % H_TOTAL;
		y = (p / H_TOTAL) % V_TOTAL - V_BORDER_T;
		c = (h - H_BORDER_L + 8) / 8;
		if (attr_rd)
			return 13'(6144 + (y / 8) * 32 + c);
		return {y[7:6], y[2:0], y[5:3], c[4:0]};
	endfunction

	function automatic logic [2:0] border_at(input int n);
		int f;
		int v;
		if (n < 0)
			return border_tab[0];
		f = n / FRAME;
		v = (n % FRAME) / H_TOTAL;
		return (v > V_SYNC_START) ? border_tab[f + 1] : border_tab[f];
	endfunction

	function automatic logic [1:0] level(input logic on, input logic bright);
		if (!on)
			return 2'd0;
		return bright ? 2'd3 : 2'd2;
	endfunction

	// {strobe, red, green, blue, hsync_n, vsync_n, csync_n, int_n} for position n
	function automatic logic [10:0] expected_outputs(input int n, input logic [2:0] bdr);
		int          f;
		int          r;
		int          h;
		int          v;
		int          x;
		int          y;
		logic        hs;
		logic        vs;
		logic        irq;
		logic        ink;
		logic        bright;
		logic        strobe;
		logic [2:0]  grb;
		logic [12:0] baddr;
		logic [7:0]  bmp;
		logic [7:0]  attr;
		logic [5:0]  rgb;
		strobe = fetch_cycle(n + 1) || fetch_cycle(n + 2);
		grb    = bdr;
		bright = 1'b0;
		hs     = 1'b0;
		vs     = 1'b0;
		irq    = 1'b0;
		if (n >= 0)
		begin
			f   = n / FRAME;
			r   = n % FRAME;
			h   = r % H_TOTAL;
			v   = r / H_TOTAL;
			hs  = (h >= H_SYNC_START) && (h < H_SYNC_START + H_SYNC_LEN);
			vs  = (v >= V_SYNC_START) && (v < V_SYNC_START + V_SYNC_LEN);
			irq = (r >= V_SYNC_START * H_TOTAL) && (r < V_SYNC_START * H_TOTAL + INT_LEN);
			if (h >= H_BORDER_L && h < H_BORDER_L + 256
				&& v >= V_BORDER_T && v < V_BORDER_T + 192)
			begin
				x     = h - H_BORDER_L;
				y     = v - V_BORDER_T;
				baddr = {y[7:6], y[2:0], y[5:3], x[7:3]};
				bmp   = mem[baddr];
				attr  = mem[6144 + (y / 8) * 32 + x / 8];
				// flash swaps ink and paper in frames 16..31 of each 32
				ink    = bmp[7 - x % 8] ^ (attr[7] & f[4]);
				grb    = ink ? attr[2:0] : attr[5:3];
				bright = attr[6];
			end
		end
		// still dark while the pipe fills after reset
		if (n < 0 || hs || vs)
			rgb = 6'd0;
		else
			rgb = {level(grb[1], bright), level(grb[2], bright), level(grb[0], bright)};
		return {strobe, rgb, ~hs, ~vs, ~(hs | vs), ~irq};
	endfunction

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		if (got !== expected)
		begin
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare, mid-cycle when outputs are settled
	////////////////////////////////////////////////////////////////////////////

	always @(negedge fclk)
	begin
		if (!rst_n || edge_cnt == 0)
			want = {1'b0, 6'd0, 4'b1111};
		else
		begin
			pos  = edge_cnt - 1 - PIPE_LAT;
			want = expected_outputs(pos, border_at(pos));
		end
		compare_value("video_strobe", video_strobe, want[10]);
		// bitmap address on the first strobe cycle, attribute on the second
		if (want[10] && fetch_cycle(pos + 2))
			compare_value("video_addr", video_addr, fetch_addr(pos + 2, 1'b0));
		else if (want[10])
			compare_value("video_addr", video_addr, fetch_addr(pos + 1, 1'b1));
		compare_value("vred", vred, want[9:8]);
		compare_value("vgrn", vgrn, want[7:6]);
		compare_value("vblu", vblu, want[5:4]);
		compare_value("vhsync", vhsync, want[3]);
		compare_value("vvsync", vvsync, want[2]);
		compare_value("vcsync", vcsync, want[1]);
		compare_value("int_n", int_n, want[0]);
	end

	initial
	begin
		seed  = 32'h8666;
		dummy = $urandom(seed);
		for (i = 0; i < 6912; i++)
			mem[i] = 8'($urandom());
		for (i = 0; i < RUN_FRAMES + 2; i++)
			border_tab[i] = 3'($urandom());
		border = border_tab[0];
		repeat (3) @(posedge fclk);
		rst_n <= 1'b1;
		wait (edge_cnt == RUN_CYCLES);
		@(negedge fclk);
		#1;
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== zx_video.f ====
rtl/video_timing_pkg.sv
rtl/video_mem_pkg.sv
rtl/raster_timing.sv
rtl/screen_fetch.sv
rtl/attr_decode.sv
rtl/video_out.sv
rtl/zx_video.sv
test/tb_zx_video.sv
